//--- common/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32

`define RESET_PC    32'h0000_0000

// primary opcodes.
`define OPC_RTYPE   6'h00
`define OPC_ADDIU   6'h09
`define OPC_SLTI    6'h0a
`define OPC_ANDI    6'h0c
`define OPC_ORI     6'h0d
`define OPC_XORI    6'h0e
`define OPC_LUI     6'h0f
`define OPC_LW      6'h23
`define OPC_SW      6'h2b

// funct field of SPECIAL.
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

`endif

//--- common/mips_pkg.sv
`default_nettype none
`include "mips_config.svh"

package mips_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,    // must stay zero, reset bubbles rely on it.
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS    // passes operand b through.
    } alu_op_e;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`DATA_W-1:0]     op_a;
        logic [`DATA_W-1:0]     op_b;    // also the store data.
        logic [`DATA_W-1:0]     imm;
        logic                   use_imm;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   reg_we;
        logic                   is_load;
        logic                   is_store;
    } id_ex_t;

    typedef struct packed {
        logic [`DATA_W-1:0]     result;  // alu result or memory address.
        logic [`DATA_W-1:0]     store_data;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   reg_we;
        logic                   is_load;
        logic                   is_store;
    } ex_mm_t;

    typedef struct packed {
        logic [`DATA_W-1:0]     value;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   reg_we;
    } mm_wb_t;

    typedef struct packed {
        logic                   reg_we;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`DATA_W-1:0]     value;
        logic                   is_load;
    } fwd_t;

endpackage

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  inst_u  inst_i,
    input  fwd_t   ex_fwd_i,
    input  fwd_t   mm_fwd_i,
    input  fwd_t   wb_fwd_i,
    input  mm_wb_t wb_i,
    input  logic   mem_stall_i,
    output logic   fetch_hold_o,
    output id_ex_t id_ex_o
);

    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`DATA_W-1:0]     rf_a;
    logic [`DATA_W-1:0]     rf_b;
    logic [`DATA_W-1:0]     imm_sext;
    logic [`DATA_W-1:0]     imm_zext;
    logic [`DATA_W-1:0]     imm_lui;
    logic                   use_rs;
    logic                   use_rt;
    logic                   load_use;
    id_ex_t                 id_ex_d;

    // taps aimed at r0 never match.
    function automatic logic tap_hit(input fwd_t tap, input logic [`REG_ADDR_W-1:0] src);
        return tap.reg_we && (tap.dest != '0) && (tap.dest == src);
    endfunction

    function automatic logic [`DATA_W-1:0] fwd_mux(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`DATA_W-1:0]     rf_val,
        input fwd_t                   ex_tap,
        input fwd_t                   mm_tap,
        input fwd_t                   wb_tap
    );
        if (tap_hit(ex_tap, src)) begin
            return ex_tap.value;  // youngest wins.
        end else if (tap_hit(mm_tap, src)) begin
            return mm_tap.value;
        end else if (tap_hit(wb_tap, src)) begin
            return wb_tap.value;
        end
        return rf_val;
    endfunction

    assign rs = inst_i.r.rs;
    assign rt = inst_i.r.rt;
    assign imm_sext = {{(`DATA_W-16){inst_i.i.imm[15]}}, inst_i.i.imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, inst_i.i.imm};
    assign imm_lui = {inst_i.i.imm, 16'h0000};

    reg_file main_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_a_i (rs),
        .raddr_b_i (rt),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .we_i      (wb_i.reg_we),
        .waddr_i   (wb_i.dest),
        .wdata_i   (wb_i.value)
    );

    always_comb begin
        id_ex_d = '0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        id_ex_d.op_a = fwd_mux(rs, rf_a, ex_fwd_i, mm_fwd_i, wb_fwd_i);
        id_ex_d.op_b = fwd_mux(rt, rf_b, ex_fwd_i, mm_fwd_i, wb_fwd_i);
        id_ex_d.imm = imm_sext;
        case (inst_i.i.opcode)
            `OPC_RTYPE: begin
                case (inst_i.r.funct)
                    `FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    `FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    `FN_AND:  id_ex_d.alu_op = ALU_AND;
                    `FN_OR:   id_ex_d.alu_op = ALU_OR;
                    `FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                    `FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    `FN_SLTU: id_ex_d.alu_op = ALU_SLTU;
                    default:  id_ex_d.alu_op = ALU_NOP;
                endcase
                id_ex_d.dest = inst_i.r.rd;
                id_ex_d.reg_we = (id_ex_d.alu_op != ALU_NOP);
                use_rs = id_ex_d.reg_we;
                use_rt = id_ex_d.reg_we;
            end
            `OPC_ADDIU: begin
                id_ex_d.alu_op = ALU_ADD;
                use_rs = 1'b1;
            end
            `OPC_SLTI: begin
                id_ex_d.alu_op = ALU_SLT;
                use_rs = 1'b1;
            end
            `OPC_ANDI: begin
                id_ex_d.alu_op = ALU_AND;
                id_ex_d.imm = imm_zext;
                use_rs = 1'b1;
            end
            `OPC_ORI: begin
                id_ex_d.alu_op = ALU_OR;
                id_ex_d.imm = imm_zext;
                use_rs = 1'b1;
            end
            `OPC_XORI: begin
                id_ex_d.alu_op = ALU_XOR;
                id_ex_d.imm = imm_zext;
                use_rs = 1'b1;
            end
            `OPC_LUI: begin
                id_ex_d.alu_op = ALU_PASS;
                id_ex_d.imm = imm_lui;
            end
            `OPC_LW: begin
                id_ex_d.alu_op = ALU_ADD;
                id_ex_d.is_load = 1'b1;
                use_rs = 1'b1;
            end
            `OPC_SW: begin
                id_ex_d.alu_op = ALU_ADD;
                id_ex_d.is_store = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;  // store data.
            end
            default: ;
        endcase
        // I-format writes rt and takes the immediate as operand b.
        if (inst_i.i.opcode != `OPC_RTYPE && id_ex_d.alu_op != ALU_NOP) begin
            id_ex_d.use_imm = 1'b1;
            id_ex_d.dest = inst_i.i.rt;
            id_ex_d.reg_we = !id_ex_d.is_store;
        end
    end

    // load in EX cannot forward yet.
    assign load_use = ex_fwd_i.is_load &&
                      ((use_rs && tap_hit(ex_fwd_i, rs)) || (use_rt && tap_hit(ex_fwd_i, rt)));
    assign fetch_hold_o = mem_stall_i || load_use;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o <= '0;
        end else if (!mem_stall_i) begin
            if (load_use) begin
                id_ex_o <= '0;  // bubble.
            end else begin
                id_ex_o <= id_ex_d;
            end
        end
    end

    bubble_is_inert: assert property (
        @(posedge clk) disable iff (!rst_n)
        (id_ex_o.alu_op == ALU_NOP) |->
            (!id_ex_o.reg_we && !id_ex_o.is_load && !id_ex_o.is_store)
    );

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`REG_ADDR_W-1:0] raddr_b_i,
    output logic [`DATA_W-1:0]     rdata_a_o,
    output logic [`DATA_W-1:0]     rdata_b_o,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`DATA_W-1:0]     wdata_i
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write-through, WB is covered by the forwarding taps.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    r0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    );

endmodule

`default_nettype wire

//--- execute/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module exec_alu
    import mips_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   hold_i,
    input  id_ex_t id_ex_i,
    output fwd_t   ex_fwd_o,
    output ex_mm_t ex_mm_o
);

    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] result;
    ex_mm_t             ex_mm_d;

    assign op_a = id_ex_i.op_a;
    assign op_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = op_a + op_b;  // also load/store address.
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(`DATA_W-1){1'b0}}, op_a < op_b};
            ALU_PASS: result = op_b;
            default:  result = '0;
        endcase
    end

    // value is meaningless for a load, decode stalls on it instead.
    always_comb begin
        ex_fwd_o.reg_we = id_ex_i.reg_we;
        ex_fwd_o.dest = id_ex_i.dest;
        ex_fwd_o.value = result;
        ex_fwd_o.is_load = id_ex_i.is_load;
    end

    always_comb begin
        ex_mm_d.result = result;
        ex_mm_d.store_data = id_ex_i.op_b;
        ex_mm_d.dest = id_ex_i.dest;
        ex_mm_d.reg_we = id_ex_i.reg_we;
        ex_mm_d.is_load = id_ex_i.is_load;
        ex_mm_d.is_store = id_ex_i.is_store;
    end

    // EX/MM register, held while the data bus stalls.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mm_o <= '0;
        end else if (!hold_i) begin
            ex_mm_o <= ex_mm_d;
        end
    end

endmodule

`default_nettype wire

//--- execute/mem_writeback.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module mem_writeback
    import mips_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  ex_mm_t             ex_mm_i,
    input  logic               dbus_stall_i,
    input  logic [`DATA_W-1:0] dbus_rddata_i,
    output logic [`DATA_W-1:0] dbus_address_o,
    output logic [`DATA_W-1:0] dbus_wrdata_o,
    output logic               dbus_read_o,
    output logic               dbus_write_o,
    output logic               mem_stall_o,
    output fwd_t               mm_fwd_o,
    output fwd_t               wb_fwd_o,
    output mm_wb_t             wb_o
);

    logic [`DATA_W-1:0] mm_value;

    // bus is driven straight from EX/MM, stable while it holds.
    assign dbus_address_o = ex_mm_i.result;
    assign dbus_wrdata_o = ex_mm_i.store_data;
    assign dbus_read_o = ex_mm_i.is_load;
    assign dbus_write_o = ex_mm_i.is_store;

    assign mem_stall_o = dbus_stall_i && (ex_mm_i.is_load || ex_mm_i.is_store);
    assign mm_value = ex_mm_i.is_load ? dbus_rddata_i : ex_mm_i.result;

    always_comb begin
        mm_fwd_o.reg_we = ex_mm_i.reg_we;
        mm_fwd_o.dest = ex_mm_i.dest;
        mm_fwd_o.value = mm_value;
        mm_fwd_o.is_load = ex_mm_i.is_load;
    end

    always_comb begin
        wb_fwd_o.reg_we = wb_o.reg_we;
        wb_fwd_o.dest = wb_o.dest;
        wb_fwd_o.value = wb_o.value;
        wb_fwd_o.is_load = 1'b0;
    end

    // MM/WB register, a stalled access leaves a bubble behind.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_o <= '0;
        end else if (mem_stall_o) begin
            wb_o <= '0;
        end else begin
            wb_o.value <= mm_value;
            wb_o.dest <= ex_mm_i.dest;
            wb_o.reg_we <= ex_mm_i.reg_we;
        end
    end

    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(dbus_read_o && dbus_write_o)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+common
+incdir+testbench
common/mips_pkg.sv
decode/reg_file.sv
verilog/fetch_unit.sv
decode/decode_stage.sv
execute/exec_alu.sv
execute/mem_writeback.sv
verilog/mips_core.sv
testbench/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run the testbench, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f list.f -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

//--- testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] rng_state;
int          emit_pos;

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// initial data memory contents.
function automatic logic [31:0] dmem_fill(input int idx);
    return 32'hd00d_0000 ^ (32'(idx) * 32'h0111_1111);
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd);
    return {`OPC_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

function automatic logic [31:0] alu_word(input int sel, input logic [4:0] src,
                                         input logic [4:0] oth, input logic [4:0] dst,
                                         input logic [15:0] imm);
    case (sel)
        0:       return enc_r(`FN_ADDU, src, oth, dst);
        1:       return enc_r(`FN_SUBU, src, oth, dst);
        2:       return enc_r(`FN_AND, src, oth, dst);
        3:       return enc_r(`FN_OR, src, oth, dst);
        4:       return enc_r(`FN_XOR, src, oth, dst);
        5:       return enc_r(`FN_SLT, src, oth, dst);
        6:       return enc_r(`FN_SLTU, src, oth, dst);
        7:       return enc_i(`OPC_ADDIU, src, dst, imm);
        8:       return enc_i(`OPC_SLTI, src, dst, imm);
        9:       return enc_i(`OPC_ANDI, src, dst, imm);
        10:      return enc_i(`OPC_ORI, src, dst, imm);
        11:      return enc_i(`OPC_XORI, src, dst, imm);
        default: return enc_i(`OPC_LUI, 5'd0, dst, imm);
    endcase
endfunction

task automatic emit(input logic [31:0] w);
    imem[emit_pos] = w;
    emit_pos++;
endtask

task automatic gen_program();
    logic [31:0] r;
    logic [4:0]  src;
    logic [4:0]  prev;
    logic [4:0]  d1;
    logic [4:0]  d2;
    int          op_idx;
    int          iter;
    rng_state = 32'h36bf;
    emit_pos = 0;
    op_idx = 0;
    iter = 0;
    prev = 5'd1;
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = '0;  // no-op padding.
    end
    emit(enc_i(`OPC_ADDIU, 5'd0, 5'd0, 16'h7ff1));  // r0 write, then store r0.
    emit(enc_i(`OPC_SW, 5'd0, 5'd0, 16'd60));
    while (emit_pos <= PROG_LEN - 4) begin
        r = xorshift32();
        src = prev;
        d1 = {2'b00, r[5:3]};
        d2 = {2'b00, r[15:13]};
        if (iter % 3 == 0) begin
            src = {2'b00, r[2:1], 1'b1};
            emit(enc_i(`OPC_LW, 5'd0, src, {10'd0, r[12:9], 2'b00}));
        end
        // chained pair, the store reads the youngest result.
        emit(alu_word(op_idx % 13, src, {2'b00, r[21:19]}, d1, r[31:16]));
        emit(alu_word((op_idx + 1) % 13, d1, src, d2, ~r[31:16]));
        emit(enc_i(`OPC_SW, 5'd0, d2, {10'd0, r[25:22], 2'b00}));
        op_idx = op_idx + 2;
        prev = d2;
        iter++;
    end
endtask

// in-order ISA model, collects the expected stores.
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  dst;
    logic        we;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] = dmem_fill(i);
    end
    exp_addr.delete();
    exp_data.delete();
    for (int pc = 0; pc < PROG_LEN; pc++) begin
        w = imem[pc];
        a = regs[w[25:21]];
        b = regs[w[20:16]];
        sx = {{16{w[15]}}, w[15:0]};
        zx = {16'h0000, w[15:0]};
        addr = a + sx;
        dst = w[20:16];
        we = 1'b1;
        res = '0;
        case (w[31:26])
            `OPC_RTYPE: begin
                dst = w[15:11];
                case (w[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    `FN_SLTU: res = {31'd0, a < b};
                    default:  we = 1'b0;
                endcase
            end
            `OPC_ADDIU: res = a + sx;
            `OPC_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
            `OPC_ANDI:  res = a & zx;
            `OPC_ORI:   res = a | zx;
            `OPC_XORI:  res = a ^ zx;
            `OPC_LUI:   res = {w[15:0], 16'h0000};
            `OPC_LW:    res = mem[addr[5:2]];
            `OPC_SW: begin
                we = 1'b0;
                mem[addr[5:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            default:    we = 1'b0;
        endcase
        if (we && dst != 5'd0) begin
            regs[dst] = res;
        end
    end
endtask

`endif

//--- testbench/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module tb_mips_core;

    localparam int PROG_LEN = 96;
    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 16;
    localparam int STORE_TIMEOUT = 3000;
    localparam int DRAIN_CYCLES = 40;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        rd;
        logic        wr;
    } dbus_snap_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        dbus_stall = 1'b0;
    logic [31:0] ibus_address;
    logic [31:0] ibus_rddata;
    logic [31:0] dbus_address;
    logic [31:0] dbus_wrdata;
    logic [31:0] dbus_rddata;
    logic        dbus_read;
    logic        dbus_write;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_idx;
    logic        first_cycle;
    logic        access_held;
    logic [31:0] prev_ibus;
    dbus_snap_t  held_bus;

    `include "tb_ref_model.svh"

    mips_core dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address),
        .ibus_rddata_i  (ibus_rddata),
        .dbus_address_o (dbus_address),
        .dbus_wrdata_o  (dbus_wrdata),
        .dbus_read_o    (dbus_read),
        .dbus_write_o   (dbus_write),
        .dbus_rddata_i  (dbus_rddata),
        .dbus_stall_i   (dbus_stall)
    );

    always #2 clk = ~clk;

    // no-ops past the end of the program.
    assign ibus_rddata = (ibus_address[31:9] == '0) ? imem[ibus_address[8:2]] : '0;
    assign dbus_rddata = dbus_read ? dmem[dbus_address[5:2]] : 32'hbad0_beef;  // read only.

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= dmem_fill(i);
            end
        end else if (dbus_write && !dbus_stall) begin
            dmem[dbus_address[5:2]] <= dbus_wrdata;
        end
    end

    always @(posedge clk) begin
        dbus_stall <= rst_n && ((xorshift32() % 32'd3) == 32'd0);
    end

    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped by a failed check");
    endtask

    task automatic fail_with(input string why);
        $display("%s (time %0t)", why, $time);
        stop_on_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error at %0t: %s expected %08h, got %08h", $time, name, expected, actual);
        stop_on_failure();
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            first_cycle <= 1'b1;
            access_held <= 1'b0;
            store_idx <= 0;
        end else begin
            first_cycle <= 1'b0;
            if (first_cycle) begin
                assert (!dbus_read) else report_mismatch("dbus_read_o", 32'd0, 32'(dbus_read));
                assert (!dbus_write) else report_mismatch("dbus_write_o", 32'd0, 32'(dbus_write));
                assert (ibus_address == `RESET_PC)
                    else report_mismatch("ibus_address_o", `RESET_PC, ibus_address);
            end else begin
                assert (ibus_address == prev_ibus || ibus_address == prev_ibus + 32'd4)
                    else report_mismatch("ibus_address_o", prev_ibus + 32'd4, ibus_address);
            end
            if (access_held) begin  // stalled access must not move.
                assert (dbus_address == held_bus.addr)
                    else report_mismatch("dbus_address_o", held_bus.addr, dbus_address);
                assert (dbus_wrdata == held_bus.wdata)
                    else report_mismatch("dbus_wrdata_o", held_bus.wdata, dbus_wrdata);
                assert (dbus_read == held_bus.rd)
                    else report_mismatch("dbus_read_o", 32'(held_bus.rd), 32'(dbus_read));
                assert (dbus_write == held_bus.wr)
                    else report_mismatch("dbus_write_o", 32'(held_bus.wr), 32'(dbus_write));
            end
            if (dbus_write && !dbus_stall) begin
                assert (store_idx < exp_addr.size())
                    else fail_with("a store arrived after the last expected one");
                assert (dbus_address == exp_addr[store_idx])
                    else report_mismatch("dbus_address_o", exp_addr[store_idx], dbus_address);
                assert (dbus_wrdata == exp_data[store_idx])
                    else report_mismatch("dbus_wrdata_o", exp_data[store_idx], dbus_wrdata);
                store_idx <= store_idx + 1;
            end
            access_held <= dbus_stall && (dbus_read || dbus_write);
            held_bus <= {dbus_address, dbus_wrdata, dbus_read, dbus_write};
            prev_ibus <= ibus_address;
        end
    end

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (store_idx < exp_addr.size()) begin
            if (cycles >= STORE_TIMEOUT) begin
                fail_with("timeout while waiting for the expected stores");
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        gen_program();
        run_model();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_for_stores();
        repeat (DRAIN_CYCLES) @(posedge clk);  // room for a stray extra store.
        if (store_idx == exp_addr.size()) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_with("store count differs from the reference model");
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module fetch_unit
    import mips_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold_i,
    output logic [`DATA_W-1:0] ibus_address_o,
    input  logic [`DATA_W-1:0] ibus_rddata_i,
    output inst_u              inst_o
);

    logic [`DATA_W-1:0] pc_q;
    inst_u              inst_q;

    assign ibus_address_o = pc_q;
    assign inst_o = inst_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (!hold_i) begin
            pc_q <= pc_q + `DATA_W'd4;
        end
    end

    // IF/ID register, all zero is a no-op.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_q <= '0;
        end else if (!hold_i) begin
            inst_q <= ibus_rddata_i;  // bus word arrives in the same cycle.
        end
    end

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_config.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    output logic [`DATA_W-1:0] ibus_address_o,
    input  logic [`DATA_W-1:0] ibus_rddata_i,
    output logic [`DATA_W-1:0] dbus_address_o,
    output logic [`DATA_W-1:0] dbus_wrdata_o,
    output logic               dbus_read_o,
    output logic               dbus_write_o,
    input  logic [`DATA_W-1:0] dbus_rddata_i,
    input  logic               dbus_stall_i
);

    inst_u  id_inst;
    logic   fetch_hold;
    logic   mem_stall;
    fwd_t   ex_fwd;
    fwd_t   mm_fwd;
    fwd_t   wb_fwd;
    mm_wb_t wb;
    id_ex_t id_ex;
    ex_mm_t ex_mm;

    fetch_unit stage_if (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold_i         (fetch_hold),  // load-use or data bus stall.
        .ibus_address_o (ibus_address_o),
        .ibus_rddata_i  (ibus_rddata_i),
        .inst_o         (id_inst)
    );

    decode_stage stage_id (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (id_inst),
        .ex_fwd_i     (ex_fwd),
        .mm_fwd_i     (mm_fwd),
        .wb_fwd_i     (wb_fwd),
        .wb_i         (wb),
        .mem_stall_i  (mem_stall),
        .fetch_hold_o (fetch_hold),
        .id_ex_o      (id_ex)
    );

    exec_alu stage_ex (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold_i   (mem_stall),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_mm_o  (ex_mm)
    );

    mem_writeback stage_mw (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_mm_i        (ex_mm),
        .dbus_stall_i   (dbus_stall_i),
        .dbus_rddata_i  (dbus_rddata_i),
        .dbus_address_o (dbus_address_o),
        .dbus_wrdata_o  (dbus_wrdata_o),
        .dbus_read_o    (dbus_read_o),
        .dbus_write_o   (dbus_write_o),
        .mem_stall_o    (mem_stall),
        .mm_fwd_o       (mm_fwd),
        .wb_fwd_o       (wb_fwd),
        .wb_o           (wb)
    );

endmodule

`default_nettype wire
